// File: design/imuldiv_pkg.sv
// shared types for the iterative multiply/divide unit
// imported by the divider, the multiplier and the top level

package imuldiv_pkg;

  // --------------------------------------------------
  // data widths
  // --------------------------------------------------

  // one 32-bit operand or one half of a result
  typedef logic [31:0] word_t;

  // divide packs remainder high and quotient low
  // multiply returns the whole signed product
  typedef logic [63:0] result_t;

  // step counter, 32 steps per operation
  typedef logic [4:0] iter_count_t;

  // --------------------------------------------------
  // request message
  // --------------------------------------------------

  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } muldiv_fn_t;

  // 66 bits, fn in the top bits
  typedef struct packed {
    muldiv_fn_t fn;
    word_t      a;
    word_t      b;
  } muldiv_req_t;

  // idle / calc / done, used by both iterative blocks
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } iter_state_t;

endpackage

// File: design/int_div_dpath.sv
// datapath of the iterative restoring divider
// steered by int_div_ctrl through enables and mux selects

module int_div_dpath (
  input  logic                      clk,
  input  logic                      reset,
  input  imuldiv_pkg::muldiv_req_t  req_msg,
  input  logic                      a_en,
  input  logic                      b_en,
  input  logic                      a_mux_sel,
  input  logic                      sub_mux_sel,
  input  logic                      sign_en,
  output logic                      sub_negative,
  output logic                      count_done,
  output imuldiv_pkg::result_t      resp_msg
);

  import imuldiv_pkg::*;

  // --------------------------------------------------
  // operand preparation
  // --------------------------------------------------

  logic  is_signed;
  word_t a_mag;
  word_t b_mag;

  // only the signed divide works on magnitudes
  assign is_signed = (req_msg.fn == fn_div);
  assign a_mag     = (is_signed && req_msg.a[31]) ? -req_msg.a : req_msg.a;
  assign b_mag     = (is_signed && req_msg.b[31]) ? -req_msg.b : req_msg.b;

  // --------------------------------------------------
  // shift and subtract step
  // --------------------------------------------------

  // a_reg holds remainder in [63:32] and quotient in [31:0]
  // bit 64 catches the borrow of the trial subtract
  logic [64:0] a_reg;
  logic [64:0] b_reg;
  logic [64:0] a_shift;
  logic [64:0] sub_out;
  logic [64:0] sub_mux_out;
  logic [64:0] a_mux_out;

  assign a_shift      = a_reg << 1;
  assign sub_out      = a_shift - b_reg;
  assign sub_negative = sub_out[64];

  // keep the difference with a one, or restore the shifted value with a zero
  assign sub_mux_out = sub_mux_sel ? {sub_out[64:1], 1'b1} : {a_shift[64:1], 1'b0};

  // load selects the fresh dividend
  assign a_mux_out = a_mux_sel ? sub_mux_out : {33'b0, a_mag};

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_out;
    end
    // divisor sits aligned with the remainder half
    if (b_en) begin
      b_reg <= {1'b0, b_mag, 32'b0};
    end
  end

  // --------------------------------------------------
  // step counter
  // --------------------------------------------------

  iter_count_t count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (a_en && !a_mux_sel) begin
      // cleared on load
      count <= '0;
    end else if (a_en) begin
      count <= count + 5'd1;
    end
  end

  // high during the last of the 32 steps
  assign count_done = (count == 5'd31);

  // --------------------------------------------------
  // sign fix-up
  // --------------------------------------------------

  logic  quot_neg;
  logic  rem_neg;
  word_t quot_mag;
  word_t rem_mag;

  // quotient takes xor of signs, remainder follows the dividend
  always_ff @(posedge clk) begin
    if (sign_en) begin
      quot_neg <= is_signed && (req_msg.a[31] ^ req_msg.b[31]);
      rem_neg  <= is_signed && req_msg.a[31];
    end
  end

  assign quot_mag = a_reg[31:0];
  assign rem_mag  = a_reg[63:32];

  assign resp_msg = {rem_neg ? -rem_mag : rem_mag, quot_neg ? -quot_mag : quot_mag};

endmodule

// File: design/int_div_ctrl.sv
// control FSM of the iterative divider
// runs the val/rdy handshake and drives the datapath selects

module int_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  input  logic sub_negative,
  input  logic count_done,
  output logic req_rdy,
  output logic resp_val,
  output logic a_en,
  output logic b_en,
  output logic a_mux_sel,
  output logic sub_mux_sel,
  output logic sign_en
);

  import imuldiv_pkg::*;

  iter_state_t state;
  iter_state_t state_next;

  // --------------------------------------------------
  // state register
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // --------------------------------------------------
  // next state and outputs
  // --------------------------------------------------

  always_comb begin
    state_next  = state;
    req_rdy     = 1'b0;
    resp_val    = 1'b0;
    a_en        = 1'b0;
    b_en        = 1'b0;
    a_mux_sel   = 1'b0;
    sub_mux_sel = 1'b0;
    sign_en     = 1'b0;

    case (state)
      st_idle: begin
        // rdy is high here, so val alone means a transfer
        req_rdy = 1'b1;
        a_en    = req_val;
        b_en    = req_val;
        sign_en = req_val;
        if (req_val) begin
          state_next = st_calc;
        end
      end

      st_calc: begin
        // one shift-subtract per edge
        a_en        = 1'b1;
        a_mux_sel   = 1'b1;
        sub_mux_sel = !sub_negative;
        if (count_done) begin
          state_next = st_done;
        end
      end

      st_done: begin
        // result held until the consumer takes it
        resp_val = 1'b1;
        if (resp_rdy) begin
          state_next = st_idle;
        end
      end

      default: state_next = st_idle;
    endcase
  end

endmodule

// File: design/int_div_iterative.sv
// iterative restoring divider, 32 steps per request
// signed and unsigned divide under one val/rdy handshake

module int_div_iterative (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_val,
  output logic                      req_rdy,
  input  imuldiv_pkg::muldiv_req_t  req_msg,
  output logic                      resp_val,
  input  logic                      resp_rdy,
  output imuldiv_pkg::result_t      resp_msg
);

  // control to datapath
  logic a_en;
  logic b_en;
  logic a_mux_sel;
  logic sub_mux_sel;
  logic sign_en;

  // status back to control
  logic sub_negative;
  logic count_done;

  int_div_dpath dpath_i (
    .clk          (clk),
    .reset        (reset),
    .req_msg      (req_msg),
    .a_en         (a_en),
    .b_en         (b_en),
    .a_mux_sel    (a_mux_sel),
    .sub_mux_sel  (sub_mux_sel),
    .sign_en      (sign_en),
    .sub_negative (sub_negative),
    .count_done   (count_done),
    .resp_msg     (resp_msg)
  );

  int_div_ctrl ctrl_i (
    .clk          (clk),
    .reset        (reset),
    .req_val      (req_val),
    .resp_rdy     (resp_rdy),
    .sub_negative (sub_negative),
    .count_done   (count_done),
    .req_rdy      (req_rdy),
    .resp_val     (resp_val),
    .a_en         (a_en),
    .b_en         (b_en),
    .a_mux_sel    (a_mux_sel),
    .sub_mux_sel  (sub_mux_sel),
    .sign_en      (sign_en)
  );

endmodule

// File: design/int_mul_iterative.sv
// iterative signed shift-and-add multiplier, 32 steps per request
// same handshake and timing as the divider

module int_mul_iterative (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_val,
  output logic                      req_rdy,
  input  imuldiv_pkg::muldiv_req_t  req_msg,
  output logic                      resp_val,
  input  logic                      resp_rdy,
  output imuldiv_pkg::result_t      resp_msg
);

  import imuldiv_pkg::*;

  // --------------------------------------------------
  // control
  // --------------------------------------------------

  iter_state_t state;
  iter_count_t count;
  logic        load;
  logic        step;

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);
  assign load     = req_val && req_rdy;
  assign step     = (state == st_calc);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (load) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          // last step when the counter reaches 31
          if (count == 5'd31) begin
            state <= st_done;
          end
          count <= count + 5'd1;
        end
        st_done: begin
          if (resp_rdy) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------

  word_t       a_mag;
  word_t       b_mag;
  logic [63:0] mcand;
  word_t       mplier;
  result_t     prod;
  logic        prod_neg;

  assign a_mag = req_msg.a[31] ? -req_msg.a : req_msg.a;
  assign b_mag = req_msg.b[31] ? -req_msg.b : req_msg.b;

  always_ff @(posedge clk) begin
    if (load) begin
      mcand    <= {32'b0, a_mag};
      mplier   <= b_mag;
      prod     <= '0;
      prod_neg <= req_msg.a[31] ^ req_msg.b[31];
    end else if (step) begin
      // add the multiplicand when the low multiplier bit is set
      if (mplier[0]) begin
        prod <= prod + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // product of magnitudes fits in 64 bits, sign applied on the way out
  assign resp_msg = prod_neg ? -prod : prod;

endmodule

// File: design/imuldiv_unit.sv
// top of the multiply/divide unit, dispatches each request by fn
// a 2-entry order queue keeps responses in request order

module imuldiv_unit (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_val,
  output logic                      req_rdy,
  input  imuldiv_pkg::muldiv_req_t  req_msg,
  output logic                      resp_val,
  input  logic                      resp_rdy,
  output imuldiv_pkg::result_t      resp_msg
);

  import imuldiv_pkg::*;

  // --------------------------------------------------
  // request steering
  // --------------------------------------------------

  logic    sel_div;
  logic    q_full;
  logic    q_empty;
  logic    mul_req_val;
  logic    mul_req_rdy;
  logic    mul_resp_val;
  logic    mul_resp_rdy;
  result_t mul_resp_msg;
  logic    div_req_val;
  logic    div_req_rdy;
  logic    div_resp_val;
  logic    div_resp_rdy;
  result_t div_resp_msg;

  // both divide flavours go to the divider
  assign sel_div = (req_msg.fn != fn_mul);

  assign mul_req_val = req_val && !sel_div && !q_full;
  assign div_req_val = req_val && sel_div && !q_full;

  assign req_rdy = (sel_div ? div_req_rdy : mul_req_rdy) && !q_full;

  // --------------------------------------------------
  // order queue
  // --------------------------------------------------

  // entry is 0 for the multiplier, 1 for the divider
  logic [1:0] q_mem;
  logic       q_head;
  logic       q_tail;
  logic [1:0] q_count;
  logic       head_div;
  logic       push;
  logic       pop;

  assign q_full   = (q_count == 2'd2);
  assign q_empty  = (q_count == 2'd0);
  assign head_div = q_mem[q_head];
  assign push     = req_val && req_rdy;
  assign pop      = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (push) begin
      q_mem[q_tail] <= sel_div;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      q_head  <= 1'b0;
      q_tail  <= 1'b0;
      q_count <= 2'd0;
    end else begin
      if (push) begin
        q_tail <= !q_tail;
      end
      if (pop) begin
        q_head <= !q_head;
      end
      // push and pop together leave the count alone
      if (push && !pop) begin
        q_count <= q_count + 2'd1;
      end else if (pop && !push) begin
        q_count <= q_count - 2'd1;
      end
    end
  end

  // --------------------------------------------------
  // response mux
  // --------------------------------------------------

  // only the block at the head may hand over its result
  assign resp_val     = !q_empty && (head_div ? div_resp_val : mul_resp_val);
  assign resp_msg     = head_div ? div_resp_msg : mul_resp_msg;
  assign mul_resp_rdy = resp_rdy && !q_empty && !head_div;
  assign div_resp_rdy = resp_rdy && !q_empty && head_div;

  int_mul_iterative mul_i (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .req_msg  (req_msg),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .resp_msg (mul_resp_msg)
  );

  int_div_iterative div_i (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .req_msg  (req_msg),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy),
    .resp_msg (div_resp_msg)
  );

endmodule

// File: bench/imuldiv_props.sv
// handshake assertions on the response side of the multiply/divide unit
// bound into every imuldiv_unit, failures are also counted for the testbench

module imuldiv_props (
  input logic                 clk,
  input logic                 reset,
  input logic                 resp_val,
  input logic                 resp_rdy,
  input imuldiv_pkg::result_t resp_msg
);

  timeunit 1ns;
  timeprecision 100ps;

  // read by the testbench at the end of the run
  int fail_count = 0;

  // nothing is offered in the cycle after reset
  reset_idle: assert property (@(posedge clk) reset |=> !resp_val)
    else begin
      $error("resp_val high in the cycle after reset");
      fail_count++;
    end

  // a waiting response keeps its value
  resp_stable: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> $stable(resp_msg))
    else begin
      $error("resp_msg changed while waiting");
      fail_count++;
    end

  // once offered, the response stays offered until taken
  resp_held: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val)
    else begin
      $error("resp_val dropped before the response was taken");
      fail_count++;
    end

endmodule

bind imuldiv_unit imuldiv_props props_i (.*);

// File: bench/imuldiv_tb.sv
// directed testbench for the multiply/divide unit
// each response is compared with a reference model, in request order

module imuldiv_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import imuldiv_pkg::*;

  logic        clk;
  logic        reset;
  logic        req_val;
  logic        req_rdy;
  muldiv_req_t req_msg;
  logic        resp_val;
  logic        resp_rdy;
  result_t     resp_msg;

  int      errors;
  int      checks;
  integer  seed;
  // expected results, pushed when a request is accepted
  result_t exp_q[$];

  imuldiv_unit dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // 400 operations of at most 40 cycles each
  initial begin
    #(400 * 40 * 10);
    $display("watchdog expired before all tests finished");
    $display("Test FAILED");
    $finish;
  end

  // --------------------------------------------------
  // reference model and handshake helpers
  // --------------------------------------------------

  // mul gives the full product, divides give remainder high and quotient low
  function automatic result_t ref_result(muldiv_fn_t fn, word_t a, word_t b);
    longint sa;
    longint sb;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    case (fn)
      fn_mul:  return sa * sb;
      // truncating divide, remainder takes the dividend's sign
      fn_div:  return {word_t'(sa % sb), word_t'(sa / sb)};
      default: return {a % b, a / b};
    endcase
  endfunction

  // entered and left 1 ns after a rising edge
  task automatic send_req(input muldiv_fn_t fn, input word_t a, input word_t b);
    req_msg.fn = fn;
    req_msg.a  = a;
    req_msg.b  = b;
    req_val    = 1'b1;
    // rdy at the falling edge holds through the next rising edge
    @(negedge clk);
    while (!req_rdy) @(negedge clk);
    exp_q.push_back(ref_result(fn, a, b));
    @(posedge clk);
    #1;
    req_val = 1'b0;
  endtask

  // holds resp_rdy low for gap cycles, then takes one response
  task automatic recv_resp(input int gap);
    result_t held;
    result_t exp;
    logic    seen;
    seen     = 1'b0;
    resp_rdy = 1'b0;
    repeat (gap) begin
      @(negedge clk);
      if (resp_val) begin
        checks++;
        if (seen && resp_msg !== held) begin
          $display("Fail resp_msg: held %h changed to %h", held, resp_msg);
          errors++;
        end
        held = resp_msg;
        seen = 1'b1;
      end
      @(posedge clk);
      #1;
    end
    resp_rdy = 1'b1;
    @(negedge clk);
    while (!resp_val) @(negedge clk);
    exp = exp_q.pop_front();
    checks++;
    if (resp_msg !== exp) begin
      $display("Fail resp_msg: expected %h actual %h", exp, resp_msg);
      errors++;
    end
    @(posedge clk);
    #1;
    resp_rdy = 1'b0;
  endtask

  task automatic run_op(input muldiv_fn_t fn, input word_t a, input word_t b);
    send_req(fn, a, b);
    recv_resp(0);
  endtask

  task automatic report_test(input string name, input int err0);
    $display("%-10s %s, %0d errors", name, (errors == err0) ? "passed" : "failed",
             errors - err0);
  endtask

  // --------------------------------------------------
  // tests
  // --------------------------------------------------

  task automatic test_reset();
    int err0;
    err0 = errors;
    @(negedge clk);
    checks += 2;
    if (req_rdy !== 1'b1) begin
      $display("Fail req_rdy: expected 1 actual %h", req_rdy);
      errors++;
    end
    if (resp_val !== 1'b0) begin
      $display("Fail resp_val: expected 0 actual %h", resp_val);
      errors++;
    end
    @(posedge clk);
    #1;
    report_test("reset", err0);
  endtask

  task automatic test_divu();
    int err0;
    err0 = errors;
    run_op(fn_divu, 32'd7, 32'd10);
    run_op(fn_divu, 32'd100, 32'd7);
    run_op(fn_divu, 32'hdeadbeef, 32'd1);
    run_op(fn_divu, 32'hffffffff, 32'hffffffff);
    run_op(fn_divu, 32'hffffffff, 32'h00010000);
    report_test("divu", err0);
  endtask

  task automatic test_div();
    int err0;
    err0 = errors;
    run_op(fn_div, 100, 7);
    run_op(fn_div, -100, 7);
    run_op(fn_div, 100, -7);
    run_op(fn_div, -100, -7);
    run_op(fn_div, 32'h80000000, 3);
    report_test("div", err0);
  endtask

  task automatic test_mul();
    int err0;
    err0 = errors;
    run_op(fn_mul, 3, -5);
    run_op(fn_mul, -1, -1);
    run_op(fn_mul, 32'h7fffffff, 32'h7fffffff);
    run_op(fn_mul, 32'h80000000, 32'h80000000);
    run_op(fn_mul, 32'h80000000, 32'h7fffffff);
    report_test("mul", err0);
  endtask

  // divide then multiply, the divide result waits under back-pressure
  task automatic test_order();
    int err0;
    err0 = errors;
    send_req(fn_div, -1000, 33);
    send_req(fn_mul, 123456, -789);
    recv_resp(50);
    recv_resp(3);
    report_test("order", err0);
  endtask

  task automatic test_random();
    muldiv_fn_t r_fn[300];
    word_t      r_a[300];
    word_t      r_b[300];
    int         r_gap[300];
    int         err0;
    err0 = errors;
    // drawn up front so both processes see a fixed sequence
    for (int i = 0; i < 300; i++) begin
      r_fn[i]  = muldiv_fn_t'($unsigned($random(seed)) % 3);
      r_a[i]   = $random(seed);
      r_b[i]   = $random(seed);
      r_gap[i] = $unsigned($random(seed)) % 4;
      if (r_fn[i] != fn_mul && r_b[i] == 32'd0) begin
        r_b[i] = 32'd1;
      end
    end
    fork
      for (int i = 0; i < 300; i++) send_req(r_fn[i], r_a[i], r_b[i]);
      for (int j = 0; j < 300; j++) recv_resp(r_gap[j]);
    join
    report_test("random", err0);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    errors   = 0;
    checks   = 0;
    seed     = 32'hd827;
    req_val  = 1'b0;
    req_msg  = '0;
    resp_rdy = 1'b0;
    reset    = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    test_reset();
    test_divu();
    test_div();
    test_mul();
    test_order();
    test_random();
    if (dut_i.props_i.fail_count != 0) begin
      $display("%0d handshake assertion failures", dut_i.props_i.fail_count);
      errors += dut_i.props_i.fail_count;
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
design/imuldiv_pkg.sv
design/int_div_dpath.sv
design/int_div_ctrl.sv
design/int_div_iterative.sv
design/int_mul_iterative.sv
design/imuldiv_unit.sv
bench/imuldiv_props.sv
bench/imuldiv_tb.sv
